/* ifetch_isa_pkg.sv */
package ifetch_isa_pkg;

	localparam int ADDR_W = 32;	// byte address width
	localparam int INSN_W = 32;	// one instruction word

	typedef logic [ADDR_W-1:0] address_t;
	typedef logic [INSN_W-1:0] instr_t;
	typedef logic [6:0] opcode_t;	// instruction bits 6..0
	typedef logic [15:0] disp_t;	// instruction bits 31..16, signed byte offset

	localparam address_t INSN_LEN = 32'd4;	// bytes per instruction
	localparam opcode_t OP_BRANCH = 7'h63;	// conditional branch

	// major opcode field of an instruction
	function automatic opcode_t insn_opcode(input instr_t ir);
		return ir[6:0];
	endfunction

	// raw displacement field
	function automatic disp_t insn_disp(input instr_t ir);
		return ir[31:16];
	endfunction

	// conditional branch with a negative offset
	function automatic logic is_back_branch(input instr_t ir);
		opcode_t op;
		disp_t d;
		op = insn_opcode(ir);
		d = insn_disp(ir);
		return (op == OP_BRANCH) && d[15];	// sign bit set means backward
	endfunction

	// displacement sign extended to a full address
	function automatic address_t branch_disp(input instr_t ir);
		disp_t d;
		d = insn_disp(ir);
		return {{(ADDR_W-16){d[15]}}, d};
	endfunction

endpackage

/* ifetch_pipe_pkg.sv */
package ifetch_pipe_pkg;

	// which buffer pair faces the issue queue
	typedef enum logic {
		BANK_AB = 1'b0,	// slots a and b presented
		BANK_CD = 1'b1	// slots c and d presented
	} bank_t;

	// the other pair
	function automatic bank_t bank_flip(input bank_t b);
		return (b == BANK_AB) ? BANK_CD : BANK_AB;
	endfunction

	// bank as seen on the fetchbuf output
	function automatic logic bank_bit(input bank_t b);
		return (b == BANK_CD);
	endfunction

endpackage

/* fetch_pair.sv */
module fetch_pair import ifetch_isa_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     load,	// fill both slots this cycle
	input  logic     load_v,	// valid value stored with the fill
	input  logic     clear0,	// invalidate slot 0
	input  logic     clear1,	// invalidate slot 1
	input  instr_t   inst0,
	input  instr_t   inst1,
	input  address_t pc_i,	// address of inst0
	output logic     v0,
	output logic     v1,
	output instr_t   instr0,
	output instr_t   instr1,
	output address_t pc0,
	output address_t pc1
);

	// valid bits, a fill beats a clear in the same cycle
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			v0 <= 1'b0;
			v1 <= 1'b0;
		end
		else if (load) begin
			v0 <= load_v;
			v1 <= load_v;
		end
		else begin
			if (clear0)
				v0 <= 1'b0;	// slot went to the queue or was flushed
			if (clear1)
				v1 <= 1'b0;
		end
	end

	// payload only moves on a fill
	always_ff @(posedge clk) begin
		if (load) begin
			instr0 <= inst0;
			instr1 <= inst1;
			pc0 <= pc_i;
			pc1 <= pc_i + INSN_LEN;	// second word follows the first
		end
	end

	// a fill only lands on a pair the queue has drained
	a_load_pair: assert property (@(posedge clk) disable iff (rst)
		load |-> !(v0 || v1));

endmodule

/* fetch_ctrl.sv */
module fetch_ctrl import ifetch_isa_pkg::*, ifetch_pipe_pkg::*; #(
	parameter address_t RESET_PC = 32'hFFFD_0000
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     hit,	// cache data valid this cycle
	input  logic     branchmiss,
	input  logic     slot0_free,	// queue tail entry free
	input  logic     slot1_free,	// entry after the tail free
	input  address_t misspc,
	input  address_t pc_i,
	input  logic     a_v,
	input  logic     b_v,
	input  logic     c_v,
	input  logic     d_v,
	input  instr_t   a_instr,
	input  instr_t   b_instr,
	input  instr_t   c_instr,
	input  instr_t   d_instr,
	input  address_t a_pc,
	input  address_t b_pc,
	input  address_t c_pc,
	input  address_t d_pc,
	output address_t pc,
	output logic     load_ab,
	output logic     load_cd,
	output logic     load_v,
	output logic     clear_a,
	output logic     clear_b,
	output logic     clear_c,
	output logic     clear_d,
	output logic     fetchbuf,
	output instr_t   fetchbuf0_instr,
	output logic     fetchbuf0_v,
	output address_t fetchbuf0_pc,
	output instr_t   fetchbuf1_instr,
	output logic     fetchbuf1_v,
	output address_t fetchbuf1_pc
);

	bank_t bank;	// pair presented to the queue
	logic miss_d;	// branchmiss seen last cycle
	logic ab_empty;
	logic cd_empty;
	logic enq_clr0;	// presented slot 0 leaves
	logic enq_clr1;	// presented slot 1 leaves
	logic enq_flip;	// presented pair drained

	// output steering from the bank pointer
	always_comb begin
		if (bank == BANK_AB) begin
			fetchbuf0_v = a_v;
			fetchbuf0_instr = a_instr;
			fetchbuf0_pc = a_pc;
			fetchbuf1_v = b_v;
			fetchbuf1_instr = b_instr;
			fetchbuf1_pc = b_pc;
		end
		else begin
			fetchbuf0_v = c_v;
			fetchbuf0_instr = c_instr;
			fetchbuf0_pc = c_pc;
			fetchbuf1_v = d_v;
			fetchbuf1_instr = d_instr;
			fetchbuf1_pc = d_pc;
		end
	end

	assign fetchbuf = bank_bit(bank);

	// enqueue table against the free flags
	always_comb begin
		enq_clr0 = 1'b0;
		enq_clr1 = 1'b0;
		enq_flip = 1'b0;
		if (slot0_free) begin
			if (fetchbuf0_v && fetchbuf1_v) begin
				enq_clr0 = 1'b1;
				enq_clr1 = slot1_free;	// second one only with room
				enq_flip = slot1_free;	// pair stays until both gone
			end
			else if (fetchbuf0_v || fetchbuf1_v) begin
				enq_clr0 = fetchbuf0_v;	// lone valid slot goes out
				enq_clr1 = fetchbuf1_v;
				enq_flip = 1'b1;
			end
		end
	end

	assign clear_a = branchmiss | ((bank == BANK_AB) & enq_clr0);
	assign clear_b = branchmiss | ((bank == BANK_AB) & enq_clr1);
	assign clear_c = branchmiss | ((bank == BANK_CD) & enq_clr0);
	assign clear_d = branchmiss | ((bank == BANK_CD) & enq_clr1);

	// refill choice, AB first
	assign ab_empty = ~a_v & ~b_v;
	assign cd_empty = ~c_v & ~d_v;
	assign load_ab = hit & ~branchmiss & ab_empty;
	assign load_cd = hit & ~branchmiss & ~ab_empty & cd_empty;
	assign load_v = ~miss_d;	// first fetch after a miss is stale

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pc <= RESET_PC;
			bank <= BANK_AB;
			miss_d <= 1'b0;
		end
		else begin
			miss_d <= branchmiss;
			if (branchmiss) begin
				pc <= misspc;	// restart at the corrected target
				bank <= BANK_AB;
			end
			else begin
				if (load_ab || load_cd)
					pc <= pc + 2 * INSN_LEN;	// two words per refill
				if (load_ab && cd_empty)
					bank <= BANK_AB;	// everything empty so restart on AB
				else if (enq_flip)
					bank <= bank_flip(bank);
			end
		end
	end

	// queue never frees its second entry alone
	a_free_order: assert property (@(posedge clk) disable iff (rst)
		slot1_free |-> slot0_free);

	// a flush leaves every slot empty so nothing was loaded beside it
	a_miss_no_load: assert property (@(posedge clk) disable iff (rst)
		branchmiss |=> !(a_v || b_v || c_v || d_v));

	// the cache answers for the address that was asked for
	a_pc_match: assert property (@(posedge clk) disable iff (rst)
		(load_ab || load_cd) |-> (pc_i == pc));

endmodule

/* backbranch_detect.sv */
module backbranch_detect import ifetch_isa_pkg::*; (
	input  logic     fetchbuf0_v,
	input  logic     fetchbuf1_v,
	input  instr_t   fetchbuf0_instr,
	input  instr_t   fetchbuf1_instr,
	input  address_t fetchbuf0_pc,
	input  address_t fetchbuf1_pc,
	output logic     branchback,
	output address_t backpc
);

	logic bb0;	// slot 0 holds a live backward branch
	logic bb1;
	address_t tgt0;
	address_t tgt1;

	assign bb0 = fetchbuf0_v & is_back_branch(fetchbuf0_instr);
	assign bb1 = fetchbuf1_v & is_back_branch(fetchbuf1_instr);

	// targets are relative to the branch itself
	assign tgt0 = fetchbuf0_pc + branch_disp(fetchbuf0_instr);
	assign tgt1 = fetchbuf1_pc + branch_disp(fetchbuf1_instr);

	assign branchback = bb0 | bb1;

	// older slot wins
	always_comb begin
		if (bb0)
			backpc = tgt0;
		else
			backpc = tgt1;
	end

endmodule

/* ifetch_top.sv */
module ifetch_top import ifetch_isa_pkg::*; #(
	parameter address_t RESET_PC = 32'hFFFD_0000
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     hit,
	input  logic     branchmiss,
	input  logic     slot0_free,
	input  logic     slot1_free,
	input  instr_t   inst0,
	input  instr_t   inst1,
	input  address_t pc_i,
	input  address_t misspc,
	output address_t pc,
	output address_t fetchbuf0_pc,
	output address_t fetchbuf1_pc,
	output address_t backpc,
	output instr_t   fetchbuf0_instr,
	output instr_t   fetchbuf1_instr,
	output logic     fetchbuf,
	output logic     fetchbuf0_v,
	output logic     fetchbuf1_v,
	output logic     branchback
);

	logic a_v, b_v, c_v, d_v;	// slot valid bits
	instr_t a_instr, b_instr, c_instr, d_instr;
	address_t a_pc, b_pc, c_pc, d_pc;
	logic load_ab;
	logic load_cd;
	logic load_v;
	logic clear_a, clear_b, clear_c, clear_d;

	fetch_ctrl #(
		.RESET_PC(RESET_PC)
	) i_ctrl (
		.clk(clk), .rst(rst), .hit(hit), .branchmiss(branchmiss),
		.slot0_free(slot0_free), .slot1_free(slot1_free),
		.misspc(misspc), .pc_i(pc_i),
		.a_v(a_v), .b_v(b_v), .c_v(c_v), .d_v(d_v),
		.a_instr(a_instr), .b_instr(b_instr), .c_instr(c_instr), .d_instr(d_instr),
		.a_pc(a_pc), .b_pc(b_pc), .c_pc(c_pc), .d_pc(d_pc),
		.pc(pc), .load_ab(load_ab), .load_cd(load_cd), .load_v(load_v),
		.clear_a(clear_a), .clear_b(clear_b), .clear_c(clear_c), .clear_d(clear_d),
		.fetchbuf(fetchbuf),
		.fetchbuf0_instr(fetchbuf0_instr), .fetchbuf0_v(fetchbuf0_v),
		.fetchbuf0_pc(fetchbuf0_pc),
		.fetchbuf1_instr(fetchbuf1_instr), .fetchbuf1_v(fetchbuf1_v),
		.fetchbuf1_pc(fetchbuf1_pc)
	);

	// first pair, slots a and b
	fetch_pair i_pair_ab (
		.clk(clk), .rst(rst), .load(load_ab), .load_v(load_v),
		.clear0(clear_a), .clear1(clear_b),
		.inst0(inst0), .inst1(inst1), .pc_i(pc_i),
		.v0(a_v), .v1(b_v), .instr0(a_instr), .instr1(b_instr),
		.pc0(a_pc), .pc1(b_pc)
	);

	// second pair, slots c and d
	fetch_pair i_pair_cd (
		.clk(clk), .rst(rst), .load(load_cd), .load_v(load_v),
		.clear0(clear_c), .clear1(clear_d),
		.inst0(inst0), .inst1(inst1), .pc_i(pc_i),
		.v0(c_v), .v1(d_v), .instr0(c_instr), .instr1(d_instr),
		.pc0(c_pc), .pc1(d_pc)
	);

	backbranch_detect i_bb (
		.fetchbuf0_v(fetchbuf0_v), .fetchbuf1_v(fetchbuf1_v),
		.fetchbuf0_instr(fetchbuf0_instr), .fetchbuf1_instr(fetchbuf1_instr),
		.fetchbuf0_pc(fetchbuf0_pc), .fetchbuf1_pc(fetchbuf1_pc),
		.branchback(branchback), .backpc(backpc)
	);

endmodule

/* tb_ifetch.sv */
module tb_ifetch import ifetch_isa_pkg::*; ;
	timeunit 1ns;
	timeprecision 1ps;

	localparam address_t RESET_PC = 32'hFFFD_0000;	// top level default
	localparam int N_CYCLES = 3000;	// random stimulus cycles
	localparam int MAX_CYCLES = N_CYCLES + 100;	// reset plus some slack

	logic clk;
	logic rst;
	logic hit;
	logic branchmiss;
	logic slot0_free;
	logic slot1_free;
	instr_t inst0;
	instr_t inst1;
	address_t pc_i;
	address_t misspc;
	address_t pc;
	address_t fetchbuf0_pc;
	address_t fetchbuf1_pc;
	address_t backpc;
	instr_t fetchbuf0_instr;
	instr_t fetchbuf1_instr;
	logic fetchbuf;
	logic fetchbuf0_v;
	logic fetchbuf1_v;
	logic branchback;

	// reference model, index 0..3 is slot a..d
	logic m_v[4];
	instr_t m_instr[4];
	address_t m_spc[4];
	logic m_bank;	// 1 presents cd
	address_t m_pc;
	logic m_miss_d;

	// what the previous cycle looked like
	logic p_miss, p_stale, p_free0, p_free1, p_fb, p_v0, p_v1;
	address_t p_misspc, p_pc0, p_pc1;
	instr_t p_i0, p_i1;

	logic [31:0] lcg_state;
	int errors;
	int cycles;
	int n_loads, n_miss, n_bb;

	ifetch_top i_dut (
		.clk(clk), .rst(rst), .hit(hit), .branchmiss(branchmiss),
		.slot0_free(slot0_free), .slot1_free(slot1_free),
		.inst0(inst0), .inst1(inst1), .pc_i(pc_i), .misspc(misspc),
		.pc(pc), .fetchbuf0_pc(fetchbuf0_pc), .fetchbuf1_pc(fetchbuf1_pc),
		.backpc(backpc), .fetchbuf0_instr(fetchbuf0_instr),
		.fetchbuf1_instr(fetchbuf1_instr), .fetchbuf(fetchbuf),
		.fetchbuf0_v(fetchbuf0_v), .fetchbuf1_v(fetchbuf1_v), .branchback(branchback)
	);

	always #10 clk = ~clk;

	// hard stop in case the stimulus loop never ends
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: simulation ran past %0d cycles", MAX_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// one in four words is a conditional branch, the rest are never branches
	function automatic instr_t make_insn(input logic [31:0] r);
		instr_t ir;
		ir = r;
		if (r[9:8] == 2'b00)
			ir[6:0] = OP_BRANCH;
		else if (ir[6:0] == OP_BRANCH)
			ir[0] = ~ir[0];
		return ir;
	endfunction

	// branch opcode with the displacement sign bit set
	function automatic logic decode_backward(input instr_t ir);
		return (ir[6:0] == OP_BRANCH) && ir[31];
	endfunction

	task automatic report_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("CHECK FAILED %s: expected %h, actual %h at %0t", name, exp, act, $time);
	endtask

	task automatic report_bit(input string name, input logic exp, input logic act);
		errors++;
		$display("CHECK FAILED %s: expected %b, actual %b at %0t", name, exp, act, $time);
	endtask

	task automatic drive_inputs;
		logic [31:0] r;
		r = next_rand();
		hit = (r[31:24] < 8'd179);	// about 70 percent
		branchmiss = (r[23:16] < 8'd8);	// about 3 percent
		slot0_free = (r[15:14] != 2'b00);
		slot1_free = r[15];	// implies slot0_free
		r = next_rand();
		misspc = {r[31:2], 2'b00};
		inst0 = make_insn(next_rand());
		inst1 = make_insn(next_rand());
		pc_i = pc;	// cache answers for the current fetch address
	endtask

	task automatic fill_pair(input int k);
		m_v[k] = !m_miss_d;	// stale right after a miss
		m_v[k+1] = !m_miss_d;
		m_instr[k] = inst0;
		m_instr[k+1] = inst1;
		m_spc[k] = pc_i;
		m_spc[k+1] = pc_i + INSN_LEN;
		m_pc = m_pc + 2 * INSN_LEN;
		n_loads++;
	endtask

	// next register state from the current state and the inputs
	task automatic step_model;
		int base;
		logic v0, v1, clr0, clr1, flip, ab_empty, cd_empty;
		base = m_bank ? 2 : 0;
		v0 = m_v[base];
		v1 = m_v[base+1];
		ab_empty = !m_v[0] && !m_v[1];
		cd_empty = !m_v[2] && !m_v[3];
		if (branchmiss) begin
			for (int i = 0; i < 4; i++)
				m_v[i] = 1'b0;
			m_pc = misspc;
			m_bank = 1'b0;
			n_miss++;
		end
		else begin
			clr0 = slot0_free && v0;
			clr1 = slot0_free && v1 && (!v0 || slot1_free);
			flip = slot0_free && (v0 || v1) && !(v0 && v1 && !slot1_free);
			if (clr0)
				m_v[base] = 1'b0;
			if (clr1)
				m_v[base+1] = 1'b0;
			if (hit && ab_empty)
				fill_pair(0);	// load wins over a clear
			else if (hit && cd_empty)
				fill_pair(2);
			if (hit && ab_empty && cd_empty)
				m_bank = 1'b0;
			else if (flip)
				m_bank = ~m_bank;
		end
		m_miss_d = branchmiss;
	endtask

	task automatic check_outputs;
		int base;
		logic bb0, bb1, exp_bb;
		address_t exp_tgt;
		base = m_bank ? 2 : 0;
		if (pc !== m_pc) report_word("steer pc", m_pc, pc);
		if (fetchbuf !== m_bank) report_bit("steer fetchbuf", m_bank, fetchbuf);
		if (fetchbuf0_v !== m_v[base]) report_bit("steer slot0 valid", m_v[base], fetchbuf0_v);
		if (fetchbuf1_v !== m_v[base+1]) report_bit("steer slot1 valid", m_v[base+1], fetchbuf1_v);
		if (m_v[base] && fetchbuf0_instr !== m_instr[base])
			report_word("steer slot0 instr", m_instr[base], fetchbuf0_instr);
		if (m_v[base] && fetchbuf0_pc !== m_spc[base])
			report_word("steer slot0 pc", m_spc[base], fetchbuf0_pc);
		if (m_v[base+1] && fetchbuf1_instr !== m_instr[base+1])
			report_word("steer slot1 instr", m_instr[base+1], fetchbuf1_instr);
		if (m_v[base+1] && fetchbuf1_pc !== m_spc[base+1])
			report_word("steer slot1 pc", m_spc[base+1], fetchbuf1_pc);

		// backward branch decode, slot 0 first
		bb0 = m_v[base] && decode_backward(m_instr[base]);
		bb1 = m_v[base+1] && decode_backward(m_instr[base+1]);
		exp_bb = bb0 || bb1;
		if (bb0)
			exp_tgt = m_spc[base] + {{16{m_instr[base][31]}}, m_instr[base][31:16]};
		else
			exp_tgt = m_spc[base+1] + {{16{m_instr[base+1][31]}}, m_instr[base+1][31:16]};
		if (exp_bb)
			n_bb++;
		if (branchback !== exp_bb) report_bit("backbranch flag", exp_bb, branchback);
		if (exp_bb && backpc !== exp_tgt) report_word("backbranch target", exp_tgt, backpc);

		if (p_miss) begin
			if (pc !== p_misspc) report_word("branch_miss pc", p_misspc, pc);
			if (fetchbuf0_v !== 1'b0) report_bit("branch_miss slot0 valid", 1'b0, fetchbuf0_v);
			if (fetchbuf1_v !== 1'b0) report_bit("branch_miss slot1 valid", 1'b0, fetchbuf1_v);
		end
		if (p_stale && fetchbuf0_v !== 1'b0)
			report_bit("branch_miss stale load", 1'b0, fetchbuf0_v);

		// no room at all, nothing presented may move
		if (!p_miss && !p_free0 && (p_v0 || p_v1)) begin
			if (fetchbuf !== p_fb) report_bit("backpressure hold bank", p_fb, fetchbuf);
			if (fetchbuf0_v !== p_v0) report_bit("backpressure hold v0", p_v0, fetchbuf0_v);
			if (fetchbuf1_v !== p_v1) report_bit("backpressure hold v1", p_v1, fetchbuf1_v);
			if (p_v0 && fetchbuf0_pc !== p_pc0) report_word("backpressure hold pc0", p_pc0, fetchbuf0_pc);
			if (p_v1 && fetchbuf1_pc !== p_pc1) report_word("backpressure hold pc1", p_pc1, fetchbuf1_pc);
			if (p_v0 && fetchbuf0_instr !== p_i0)
				report_word("backpressure hold instr0", p_i0, fetchbuf0_instr);
			if (p_v1 && fetchbuf1_instr !== p_i1)
				report_word("backpressure hold instr1", p_i1, fetchbuf1_instr);
		end
		// one entry free with a full pair, only slot 0 leaves
		if (!p_miss && p_free0 && !p_free1 && p_v0 && p_v1) begin
			if (fetchbuf !== p_fb) report_bit("backpressure single bank", p_fb, fetchbuf);
			if (fetchbuf0_v !== 1'b0) report_bit("backpressure single v0", 1'b0, fetchbuf0_v);
			if (fetchbuf1_v !== 1'b1) report_bit("backpressure single v1", 1'b1, fetchbuf1_v);
			if (fetchbuf1_instr !== p_i1) report_word("backpressure single instr1", p_i1, fetchbuf1_instr);
		end
	endtask

	// remember this cycle for the checks one cycle later
	task automatic record_cycle;
		p_miss = branchmiss;
		p_misspc = misspc;
		p_stale = m_miss_d && hit && !branchmiss;
		p_free0 = slot0_free;
		p_free1 = slot1_free;
		p_fb = fetchbuf;
		p_v0 = fetchbuf0_v;
		p_v1 = fetchbuf1_v;
		p_i0 = fetchbuf0_instr;
		p_i1 = fetchbuf1_instr;
		p_pc0 = fetchbuf0_pc;
		p_pc1 = fetchbuf1_pc;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		hit = 1'b0;
		branchmiss = 1'b0;
		slot0_free = 1'b0;
		slot1_free = 1'b0;
		inst0 = '0;
		inst1 = '0;
		pc_i = '0;
		misspc = '0;
		lcg_state = 32'd77511;
		errors = 0;
		cycles = 0;
		n_loads = 0;
		n_miss = 0;
		n_bb = 0;
		for (int i = 0; i < 4; i++) begin
			m_v[i] = 1'b0;
			m_instr[i] = '0;
			m_spc[i] = '0;
		end
		m_bank = 1'b0;
		m_pc = RESET_PC;
		m_miss_d = 1'b0;
		p_miss = 1'b0;
		p_stale = 1'b0;
		p_free0 = 1'b1;	// keeps the hold checks quiet on the first cycle
		p_free1 = 1'b1;
		p_v0 = 1'b0;
		p_v1 = 1'b0;

		repeat (3) @(posedge clk);
		#2;
		if (pc !== RESET_PC) report_word("reset pc", RESET_PC, pc);
		if (fetchbuf0_v !== 1'b0) report_bit("reset slot0 valid", 1'b0, fetchbuf0_v);
		if (fetchbuf1_v !== 1'b0) report_bit("reset slot1 valid", 1'b0, fetchbuf1_v);
		if (fetchbuf !== 1'b0) report_bit("reset fetchbuf", 1'b0, fetchbuf);
		if (branchback !== 1'b0) report_bit("reset branchback", 1'b0, branchback);
		rst = 1'b0;

		for (int n = 0; n < N_CYCLES; n++) begin
			drive_inputs();
			@(negedge clk);	// registers settled, inputs stable
			check_outputs();
			record_cycle();
			step_model();
			@(posedge clk);
			#2;
		end

		$display("cycles %0d, loads %0d, misses %0d, backward branch cycles %0d",
			N_CYCLES, n_loads, n_miss, n_bb);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* ifetch_top.f */
ifetch_isa_pkg.sv
ifetch_pipe_pkg.sv
fetch_pair.sv
fetch_ctrl.sv
backbranch_detect.sv
ifetch_top.sv
tb_ifetch.sv

/* Makefile */
# Verilator build and run for the instruction fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_ifetch
LOG       ?= sim.log
FLIST     ?= ifetch_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
